// ==== rtl/alu_cfg.svh ====
// ALU coprocessor configuration
// Datapath width, APB address width and the register map byte offsets

`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

////////////////////////////////////////
// Widths
////////////////////////////////////////
`define ALU_DATA_W 16      // Operand and result width, datapath is built for 16
`define ALU_ADDR_W 8       // APB byte address width

////////////////////////////////////////
// Register map, byte offsets
////////////////////////////////////////
`define ALU_REG_OPA    8'h00  // Operand A, read/write
`define ALU_REG_OPB    8'h04  // Operand B, read/write
`define ALU_REG_OPCODE 8'h08  // Write launches an operation
`define ALU_REG_RESULT 8'h0C  // Last result, read only
`define ALU_REG_FLAGS  8'h10  // Z/V/N flags, read only

// Bit 0 busy, bit 1 sticky opcode error
`define ALU_REG_STATUS 8'h14

`endif

// ==== rtl/alu_pkg.sv ====
// ALU coprocessor shared types
// Opcode encoding, register addresses and flag bit positions

`include "alu_cfg.svh"

package alu_pkg;

  ////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////
  // Codes 0xC..0xF are left undefined and treated as invalid
  typedef enum logic [3:0] {
    OP_ADD    = 4'h0,  // Saturating add
    OP_SUB    = 4'h1,  // Saturating subtract
    OP_XOR    = 4'h2,
    OP_RED    = 4'h3,  // Nibble reduction sum
    OP_SLL    = 4'h4,
    OP_SRA    = 4'h5,
    OP_ROR    = 4'h6,
    OP_PADDSB = 4'h7,  // Four nibble saturating adds
    OP_LW     = 4'h8,  // Address calc, wraps
    OP_SW     = 4'h9,
    OP_LLB    = 4'hA,  // Load low byte
    OP_LHB    = 4'hB   // Load high byte
  } alu_op_e;

  ////////////////////////////////////////
  // Register addresses
  ////////////////////////////////////////
  typedef enum logic [`ALU_ADDR_W-1:0] {
    REG_OPA    = `ALU_REG_OPA,
    REG_OPB    = `ALU_REG_OPB,
    REG_OPCODE = `ALU_REG_OPCODE,
    REG_RESULT = `ALU_REG_RESULT,
    REG_FLAGS  = `ALU_REG_FLAGS,
    REG_STATUS = `ALU_REG_STATUS
  } reg_addr_e;

  // Bit positions inside FLAGS
  typedef enum logic [1:0] {
    FLAG_Z = 2'd0,  // Zero
    FLAG_V = 2'd1,  // Signed overflow
    FLAG_N = 2'd2   // Negative
  } flag_bit_e;

endpackage

// ==== rtl/alu_decode.sv ====
// APB slave and register decode for the ALU coprocessor
// Holds the operand and opcode registers, launches an operation on an
// OPCODE write and inserts wait states on RESULT/FLAGS reads while busy

`include "alu_cfg.svh"

module alu_decode (
  input  logic                   clk,
  input  logic                   reset,
  // APB slave side
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`ALU_ADDR_W-1:0] paddr,
  input  logic [`ALU_DATA_W-1:0] pwdata,
  output logic [`ALU_DATA_W-1:0] prdata,
  output logic                   pready,
  // Back from the result block
  input  logic [`ALU_DATA_W-1:0] result_q,
  input  logic [2:0]             flags_q,
  input  logic                   busy,
  input  logic                   err_q,
  // Towards execute
  output logic [`ALU_DATA_W-1:0] op_a,
  output logic [`ALU_DATA_W-1:0] op_b,
  output alu_pkg::alu_op_e       opcode,
  output logic                   launch
);

  localparam int DW = `ALU_DATA_W;

  alu_pkg::reg_addr_e addr;  // Decoded register address
  logic wr_access;           // Write in its access phase
  logic rd_sel;              // Read selected, setup or access
  logic rd_wait;             // Read that has to stall

  assign addr = alu_pkg::reg_addr_e'(paddr);

  assign wr_access = psel & penable & pwrite;  // Writes never wait
  assign rd_sel    = psel & ~pwrite;

  // Only RESULT and FLAGS depend on an operation in flight
  assign rd_wait = rd_sel & penable & busy &
                   ((addr == alu_pkg::REG_RESULT) | (addr == alu_pkg::REG_FLAGS));

  assign pready = ~rd_wait;  // High when idle too

  ////////////////////////////////////////
  // Register writes and launch
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      op_a   <= '0;
      op_b   <= '0;
      opcode <= alu_pkg::OP_ADD;  // Encodes as zero
      launch <= 1'b0;
    end else begin
      // One cycle pulse, same edge that loads the opcode
      launch <= wr_access & (addr == alu_pkg::REG_OPCODE);
      if (wr_access) begin
        case (addr)
          alu_pkg::REG_OPA:    op_a <= pwdata;
          alu_pkg::REG_OPB:    op_b <= pwdata;
          alu_pkg::REG_OPCODE: opcode <= alu_pkg::alu_op_e'(pwdata[3:0]);
          default: ;  // Read only or unmapped, write dropped
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // Read data mux
  ////////////////////////////////////////
  always_comb begin
    prdata = '0;
    if (rd_sel) begin
      case (addr)
        alu_pkg::REG_OPA:    prdata = op_a;
        alu_pkg::REG_OPB:    prdata = op_b;
        alu_pkg::REG_OPCODE: prdata = {{(DW-4){1'b0}}, opcode};  // Last opcode written
        alu_pkg::REG_RESULT: prdata = result_q;
        alu_pkg::REG_FLAGS:  prdata = {{(DW-3){1'b0}}, flags_q};
        alu_pkg::REG_STATUS: prdata = {{(DW-2){1'b0}}, err_q, busy};
        default:             prdata = '0;  // Unmapped reads as zero
      endcase
    end
  end

endmodule

// ==== rtl/alu_execute.sv ====
// Registered ALU of the coprocessor
// Computes the 16-bit model CPU operations in one combinational stage and
// captures result, Z/V/N set signals and opcode on launch

`include "alu_cfg.svh"

module alu_execute (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`ALU_DATA_W-1:0] op_a,
  input  logic [`ALU_DATA_W-1:0] op_b,
  input  alu_pkg::alu_op_e       opcode,
  input  logic                   launch,
  output logic [`ALU_DATA_W-1:0] alu_out,
  output logic                   z_set,
  output logic                   v_set,
  output logic                   n_set,
  output logic                   ex_valid,
  output alu_pkg::alu_op_e       ex_op
);

  localparam int DW = `ALU_DATA_W;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Sum of the eight signed nibbles of A and B, sign extended
  function automatic logic [DW-1:0] red_sum(input logic [DW-1:0] a,
                                            input logic [DW-1:0] b);
    logic [6:0]      acc;  // -64..56 fits in 7 bits
    logic [2*DW-1:0] nib;
    acc = '0;
    nib = {a, b};
    for (int i = 0; i < 8; i++) begin
      acc = acc + {{3{nib[4*i+3]}}, nib[4*i +: 4]};
    end
    return {{(DW-7){acc[6]}}, acc};
  endfunction

  // Four independent signed nibble adds with saturation
  function automatic logic [DW-1:0] paddsb(input logic [DW-1:0] a,
                                           input logic [DW-1:0] b);
    logic [4:0]    s;  // One guard bit
    logic [DW-1:0] r;
    r = '0;
    for (int i = 0; i < 4; i++) begin
      s = {a[4*i+3], a[4*i +: 4]} + {b[4*i+3], b[4*i +: 4]};
      if (s[4] != s[3])
        r[4*i +: 4] = s[4] ? 4'h8 : 4'h7;  // Clamp toward the true sign
      else
        r[4*i +: 4] = s[3:0];
    end
    return r;
  endfunction

  ////////////////////////////////////////
  // Adder path
  ////////////////////////////////////////
  logic          addr_op;            // LW or SW
  logic [DW-1:0] in_a, in_b;         // Adder inputs after address shaping
  logic [DW-1:0] sum_step, sum_out;
  logic          pos_ov, neg_ov;     // Saturation direction
  logic [DW-1:0] sra_out;
  logic [2*DW-1:0] rot;              // Doubled word for rotate
  logic [DW-1:0] res;                // Combinational result

  assign addr_op = (opcode == alu_pkg::OP_LW) | (opcode == alu_pkg::OP_SW);

  // Address calc is (A & ~1) + (B << 1)
  assign in_a = addr_op ? (op_a & 16'hFFFE) : op_a;
  assign in_b = addr_op ? {op_b[DW-2:0], 1'b0} : op_b;

  assign sum_step = (opcode == alu_pkg::OP_SUB) ? (in_a - in_b) : (in_a + in_b);

  // Overflow only counts for ADD and SUB
  assign pos_ov = ((opcode == alu_pkg::OP_ADD) & ~in_a[DW-1] & ~in_b[DW-1] &  sum_step[DW-1]) |
                  ((opcode == alu_pkg::OP_SUB) & ~in_a[DW-1] &  in_b[DW-1] &  sum_step[DW-1]);
  assign neg_ov = ((opcode == alu_pkg::OP_ADD) &  in_a[DW-1] &  in_b[DW-1] & ~sum_step[DW-1]) |
                  ((opcode == alu_pkg::OP_SUB) &  in_a[DW-1] & ~in_b[DW-1] & ~sum_step[DW-1]);

  // LW/SW never flag overflow, so they wrap
  assign sum_out = pos_ov ? 16'h7FFF :
                   neg_ov ? 16'h8000 : sum_step;

  ////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////
  assign sra_out = $signed(op_a) >>> op_b[3:0];  // Arithmetic, keeps sign
  assign rot     = {op_a, op_a} >> op_b[3:0];    // Low half is the rotate

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////
  always_comb begin
    res = '0;
    case (opcode)
      alu_pkg::OP_ADD,
      alu_pkg::OP_SUB,
      alu_pkg::OP_LW,
      alu_pkg::OP_SW:     res = sum_out;
      alu_pkg::OP_XOR:    res = op_a ^ op_b;
      alu_pkg::OP_RED:    res = red_sum(op_a, op_b);
      alu_pkg::OP_SLL:    res = op_a << op_b[3:0];
      alu_pkg::OP_SRA:    res = sra_out;
      alu_pkg::OP_ROR:    res = rot[DW-1:0];
      alu_pkg::OP_PADDSB: res = paddsb(op_a, op_b);
      alu_pkg::OP_LLB:    res = {op_a[DW-1:8], op_b[7:0]};  // Upper byte kept
      alu_pkg::OP_LHB:    res = {op_b[7:0], op_a[7:0]};     // Lower byte kept
      default:            res = '0;  // 0xC..0xF
    endcase
  end

  ////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset)
      ex_valid <= 1'b0;
    else
      ex_valid <= launch;  // One cycle behind launch
  end

  // Payload, only meaningful alongside ex_valid
  always_ff @(posedge clk) begin
    if (launch) begin
      alu_out <= res;
      z_set   <= (res == '0);
      v_set   <= pos_ov | neg_ov;
      n_set   <= res[DW-1];
      ex_op   <= opcode;
    end
  end

endmodule

// ==== rtl/alu_result.sv ====
// Result and flag registers of the ALU coprocessor
// Loads the result on ex_valid, updates Z/V/N under a per-opcode mask,
// keeps the sticky opcode error and tracks operations in flight

`include "alu_cfg.svh"

module alu_result (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   launch,
  input  logic [`ALU_DATA_W-1:0] alu_out,
  input  logic                   z_set,
  input  logic                   v_set,
  input  logic                   n_set,
  input  logic                   ex_valid,
  input  alu_pkg::alu_op_e       ex_op,
  output logic [`ALU_DATA_W-1:0] result_q,
  output logic [2:0]             flags_q,
  output logic                   busy,
  output logic                   err_q
);

  logic [1:0] inflight;  // At most two operations overlap
  logic       op_valid;

  assign op_valid = (ex_op <= alu_pkg::OP_LHB);  // 0xC..0xF undefined

  // Launch cycle counts as busy, count catches up one edge later
  assign busy = launch | (inflight != 2'd0);

  ////////////////////////////////////////
  // In-flight counter
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      inflight <= 2'd0;
    end else begin
      case ({launch, ex_valid})
        2'b10:   inflight <= inflight + 2'd1;
        2'b01:   inflight <= inflight - 2'd1;
        default: inflight <= inflight;  // Both or neither
      endcase
    end
  end

  ////////////////////////////////////////
  // Result, flags and error
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      result_q <= '0;
      flags_q  <= 3'b000;
      err_q    <= 1'b0;
    end else if (ex_valid) begin
      result_q <= alu_out;
      err_q    <= ~op_valid;  // Next valid opcode clears it
      case (ex_op)
        // Arithmetic keeps all three
        alu_pkg::OP_ADD,
        alu_pkg::OP_SUB: begin
          flags_q[alu_pkg::FLAG_Z] <= z_set;
          flags_q[alu_pkg::FLAG_V] <= v_set;
          flags_q[alu_pkg::FLAG_N] <= n_set;
        end
        alu_pkg::OP_XOR,
        alu_pkg::OP_SLL,
        alu_pkg::OP_SRA,
        alu_pkg::OP_ROR: flags_q[alu_pkg::FLAG_Z] <= z_set;  // Logic ops, Z only
        default: ;  // RED, PADDSB, LW/SW, LLB/LHB and invalid leave flags
      endcase
    end
  end

endmodule

// ==== rtl/alu_apb_top.sv ====
// ALU coprocessor top level
// APB slave decode feeding a registered ALU and the result/flag registers

`include "alu_cfg.svh"

module alu_apb_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`ALU_ADDR_W-1:0] paddr,
  input  logic [`ALU_DATA_W-1:0] pwdata,
  output logic [`ALU_DATA_W-1:0] prdata,
  output logic                   pready
);

  // Decode to execute
  logic [`ALU_DATA_W-1:0] op_a, op_b;
  alu_pkg::alu_op_e       opcode;
  logic                   launch;

  // Execute to result
  logic [`ALU_DATA_W-1:0] alu_out;
  logic                   z_set, v_set, n_set;
  logic                   ex_valid;
  alu_pkg::alu_op_e       ex_op;

  // Result back to decode
  logic [`ALU_DATA_W-1:0] result_q;
  logic [2:0]             flags_q;
  logic                   busy, err_q;

  alu_decode u_decode (
    .clk(clk), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .result_q(result_q), .flags_q(flags_q), .busy(busy), .err_q(err_q),
    .op_a(op_a), .op_b(op_b), .opcode(opcode), .launch(launch)
  );

  alu_execute u_execute (
    .clk(clk), .reset(reset),
    .op_a(op_a), .op_b(op_b), .opcode(opcode), .launch(launch),
    .alu_out(alu_out), .z_set(z_set), .v_set(v_set), .n_set(n_set),
    .ex_valid(ex_valid), .ex_op(ex_op)
  );

  alu_result u_result (
    .clk(clk), .reset(reset), .launch(launch),
    .alu_out(alu_out), .z_set(z_set), .v_set(v_set), .n_set(n_set),
    .ex_valid(ex_valid), .ex_op(ex_op),
    .result_q(result_q), .flags_q(flags_q), .busy(busy), .err_q(err_q)
  );

endmodule

// ==== tb/alu_asserts.sv ====
// Protocol and timing assertions for the ALU coprocessor
// Bound into the top level to watch the APB pins and launch, valid and busy

`include "alu_cfg.svh"

module alu_asserts (
  input logic                   clk,
  input logic                   reset,
  input logic                   psel,
  input logic                   penable,
  input logic [`ALU_DATA_W-1:0] prdata,
  input logic                   pready,
  input logic                   launch,
  input logic                   ex_valid,
  input logic                   busy
);
  timeunit 1ns;
  timeprecision 1ps;

  // Failure counts per property
  int idle_fails  = 0;
  int stall_fails = 0;
  int valid_fails = 0;
  int busy_fails  = 0;
  int fail_count;

  assign fail_count = idle_fails + stall_fails + valid_fails + busy_fails;

  ////////////////////////////////////////
  // APB side
  ////////////////////////////////////////
  // Wait states only ever inside an access phase
  idle_ready: assert property (@(posedge clk) disable iff (reset)
    !(psel && penable) |-> pready)
    else begin
      idle_fails++;
      $error("pready low while no access phase is in progress");
    end

  // Read data held from the setup phase through a stall
  stall_stable: assert property (@(posedge clk) disable iff (reset)
    !pready |-> $stable(prdata))
    else begin
      stall_fails++;
      $error("prdata changed while pready was held low");
    end

  ////////////////////////////////////////
  // Pipeline timing
  ////////////////////////////////////////
  valid_follows: assert property (@(posedge clk) disable iff (reset)
    ex_valid == $past(launch))  // Exactly one cycle behind
    else begin
      valid_fails++;
      $error("ex_valid did not follow launch after one cycle");
    end

  // Two quiet cycles after a launch leave nothing in flight
  busy_clears: assert property (@(posedge clk) disable iff (reset)
    (!launch && $past(!launch) && $past(launch, 2)) |-> !busy)
    else begin
      busy_fails++;
      $error("busy still high two cycles after the last launch");
    end

endmodule

bind alu_apb_top alu_asserts u_asserts (
  .clk(clk), .reset(reset), .psel(psel), .penable(penable), .prdata(prdata),
  .pready(pready), .launch(launch), .ex_valid(ex_valid), .busy(busy)
);

// ==== tb/alu_tb.sv ====
// Testbench for the APB ALU coprocessor
// Random and directed operations over APB, checked against a software ALU model

`include "alu_cfg.svh"

module alu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam int N_RAND       = 300;          // Random operations
  localparam int N_OPS        = N_RAND + 24;  // Directed ones on top with margin

  logic                   clk, reset, psel, penable, pwrite, pready;
  logic [`ALU_ADDR_W-1:0] paddr;
  logic [`ALU_DATA_W-1:0] pwdata, prdata;

  int         errors = 0;
  int         checks = 0;
  int         last_waits;         // Wait states seen by the last transfer
  logic [2:0] sw_flags = 3'b000;  // Software copy of FLAGS
  logic       sw_err = 1'b0;      // Sticky error model

  alu_apb_top uut (
    .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Watchdog sized from the operation count
  initial begin
    #(CLK_PERIOD * (N_OPS * 20 + RESET_CYCLES));
    $display("Timeout, the run did not reach its end in time");
    $display("Testbench failed");
    $finish;
  end

  ////////////////////////////////////////
  // APB master
  ////////////////////////////////////////
  // Entered and left 5 ns after a rising edge
  task automatic apb_xfer(input logic wr, input logic [7:0] addr,
                          input logic [15:0] wdata, output logic [15:0] rdata);
    psel    = 1'b1;  // Setup phase
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #5;
    penable    = 1'b1;  // Access phase
    last_waits = 0;
    @(negedge clk);  // Mid cycle where pready has settled
    while (!pready) begin
      last_waits++;
      @(negedge clk);
    end
    rdata = prdata;
    @(posedge clk);  // Completing edge
    #5;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [15:0] data);
    logic [15:0] dummy;
    apb_xfer(1'b1, addr, data, dummy);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [15:0] data);
    apb_xfer(1'b0, addr, 16'h0, data);
  endtask

  task automatic check_eq(input string name, input logic [15:0] exp,
                          input logic [15:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("error %s expected %h actual %h", name, exp, act);
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic logic [15:0] sat16(input int s, output logic ovf);
    ovf = (s > 32767) || (s < -32768);
    if (s > 32767) return 16'h7FFF;
    if (s < -32768) return 16'h8000;
    return s[15:0];
  endfunction

  function automatic logic [15:0] ref_alu(input logic [3:0] op, input logic [15:0] a,
                                          input logic [15:0] b, output logic ovf);
    int          sa, sb, acc, nib;
    logic [15:0] r;
    logic [3:0]  sh;
    sa  = $signed(a);
    sb  = $signed(b);
    sh  = b[3:0];  // Shift amount
    ovf = 1'b0;
    r   = 16'h0;
    acc = 0;
    case (op)
      alu_pkg::OP_ADD: r = sat16(sa + sb, ovf);
      alu_pkg::OP_SUB: r = sat16(sa - sb, ovf);
      alu_pkg::OP_XOR: r = a ^ b;
      alu_pkg::OP_RED: begin
        for (int i = 0; i < 4; i++) begin
          acc = acc + $signed(a[4*i +: 4]) + $signed(b[4*i +: 4]);
        end
        r = acc[15:0];  // Two's complement and already sign extended
      end
      alu_pkg::OP_SLL: r = a << sh;
      alu_pkg::OP_SRA: r = $signed(a) >>> sh;
      alu_pkg::OP_ROR: r = (a >> sh) | (a << (16 - sh));
      alu_pkg::OP_PADDSB: begin
        for (int i = 0; i < 4; i++) begin
          nib = $signed(a[4*i +: 4]) + $signed(b[4*i +: 4]);
          if (nib > 7) nib = 7;  // Clamp per nibble
          if (nib < -8) nib = -8;
          r[4*i +: 4] = nib[3:0];
        end
      end
      alu_pkg::OP_LW, alu_pkg::OP_SW: r = (a & 16'hFFFE) + {b[14:0], 1'b0};
      alu_pkg::OP_LLB: r = {a[15:8], b[7:0]};
      alu_pkg::OP_LHB: r = {b[7:0], a[7:0]};
      default: r = 16'h0;  // Invalid opcode
    endcase
    return r;
  endfunction

  // CPU flag mask and sticky error for one executed opcode
  task automatic update_model(input logic [3:0] op, input logic [15:0] r, input logic ovf);
    if (op == alu_pkg::OP_ADD || op == alu_pkg::OP_SUB) begin
      sw_flags[alu_pkg::FLAG_Z] = (r == 16'h0);
      sw_flags[alu_pkg::FLAG_V] = ovf;
      sw_flags[alu_pkg::FLAG_N] = r[15];
    end else if (op == alu_pkg::OP_XOR || op == alu_pkg::OP_SLL ||
                 op == alu_pkg::OP_SRA || op == alu_pkg::OP_ROR) begin
      sw_flags[alu_pkg::FLAG_Z] = (r == 16'h0);  // Z only
    end
    sw_err = (op > alu_pkg::OP_LHB);
  endtask

  // Writes operands and opcode and reads back RESULT, FLAGS and STATUS
  task automatic run_op(input logic [3:0] op, input logic [15:0] a, input logic [15:0] b);
    logic [15:0] rd, exp;
    logic        ovf;
    exp = ref_alu(op, a, b, ovf);
    update_model(op, exp, ovf);
    apb_write(`ALU_REG_OPA, a);
    apb_write(`ALU_REG_OPB, b);
    apb_write(`ALU_REG_OPCODE, {12'h0, op});
    apb_read(`ALU_REG_RESULT, rd);  // Issued while the op is in flight
    checks++;
    assert (last_waits > 0) else begin
      errors++;
      $display("RESULT read right after an OPCODE write finished without a wait state");
    end
    check_eq("result_q", exp, rd);
    apb_read(`ALU_REG_FLAGS, rd);
    check_eq("flags_q", {13'h0, sw_flags}, rd);
    apb_read(`ALU_REG_STATUS, rd);
    check_eq("status", {14'h0, sw_err, 1'b0}, rd);  // busy long gone
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    logic [7:0]  regs [6] = '{`ALU_REG_OPA, `ALU_REG_OPB, `ALU_REG_OPCODE,
                              `ALU_REG_RESULT, `ALU_REG_FLAGS, `ALU_REG_STATUS};
    logic [15:0] rd, val;
    logic        ovf;
    void'($urandom(15));  // Fixed seed
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #5;
    reset = 1'b0;

    for (int i = 0; i < 6; i++) begin  // Everything zero out of reset
      apb_read(regs[i], rd);
      check_eq("reset value", 16'h0, rd);
    end
    val = 16'($urandom);
    apb_write(`ALU_REG_OPA, val);
    apb_read(`ALU_REG_OPA, rd);
    check_eq("op_a", val, rd);
    val = 16'($urandom);
    apb_write(`ALU_REG_OPB, val);
    apb_read(`ALU_REG_OPB, rd);
    check_eq("op_b", val, rd);

    // Saturation both ways and then a zero sum
    run_op(alu_pkg::OP_ADD, 16'h7FFF, 16'h0001);
    run_op(alu_pkg::OP_ADD, 16'h8000, 16'hFFFF);
    run_op(alu_pkg::OP_SUB, 16'h7FFF, 16'hFFFF);
    run_op(alu_pkg::OP_SUB, 16'h8000, 16'h0001);
    run_op(alu_pkg::OP_ADD, 16'h1234, 16'hEDCC);
    run_op(4'hC, 16'h1111, 16'h2222);  // Sets the error bit
    run_op(alu_pkg::OP_XOR, 16'h00FF, 16'h0F0F);  // and clears it

    for (int i = 0; i < N_RAND; i++) begin
      run_op(4'($urandom_range(15, 0)), 16'($urandom), 16'($urandom));
    end

    // Zero sum sets Z so only a landed XOR below can clear it
    run_op(alu_pkg::OP_ADD, 16'h1234, 16'hEDCC);

    // Two launches in a row and RESULT holds the second one
    apb_write(`ALU_REG_OPA, 16'h80F0);
    apb_write(`ALU_REG_OPB, 16'h0F0F);
    apb_write(`ALU_REG_OPCODE, {12'h0, alu_pkg::OP_XOR});
    apb_write(`ALU_REG_OPCODE, {12'h0, alu_pkg::OP_LHB});
    apb_read(`ALU_REG_RESULT, rd);
    val = ref_alu(alu_pkg::OP_XOR, 16'h80F0, 16'h0F0F, ovf);
    update_model(alu_pkg::OP_XOR, val, ovf);
    val = ref_alu(alu_pkg::OP_LHB, 16'h80F0, 16'h0F0F, ovf);
    update_model(alu_pkg::OP_LHB, val, ovf);
    check_eq("result_q", val, rd);
    apb_read(`ALU_REG_FLAGS, rd);
    check_eq("flags_q", {13'h0, sw_flags}, rd);
    apb_read(`ALU_REG_OPCODE, rd);
    check_eq("opcode", {12'h0, alu_pkg::OP_LHB}, rd);

    repeat (4) @(posedge clk);
    $display("checks %0d, errors %0d, assertion failures %0d",
             checks, errors, uut.u_asserts.fail_count);
    if (errors == 0 && uut.u_asserts.fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+rtl
rtl/alu_pkg.sv
rtl/alu_decode.sv
rtl/alu_execute.sv
rtl/alu_result.sv
rtl/alu_apb_top.sv
tb/alu_asserts.sv
tb/alu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the ALU coprocessor testbench with Verilator and run it.
# The run counts as passed only if the pass line shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module alu_tb -f flist.f -o alu_sim \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/alu_sim +verilator+error+limit+1000 | tee /dev/stderr \
  | grep -x "Testbench passed" > /dev/null \
  && exit 0 || exit 1
